//--- Makefile
VERILATOR ?= verilator
TOP       ?= mcu_periph_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	./$(SIM) | tee $(LOG)
	grep -q "^test passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- files.f
logic/mcu_periph_pkg.sv
logic/dataslot_cmd_regs.sv
logic/ms_timer.sv
logic/mcu_bus_decode.sv
logic/mcu_periph_top.sv
test/mcu_periph_checker.sv
test/mcu_periph_tb.sv

//--- logic/dataslot_cmd_regs.sv
`timescale 1ns/1ps

module dataslot_cmd_regs
	import mcu_periph_pkg::*;
(
	input  logic                      clk_sys,
	input  logic                      reset_n,

	// register access from the decoder
	input  logic                      acc_stb,
	input  logic                      acc_we,
	input  bus_addr_t                 acc_addr,
	input  word_t                     acc_wdata,
	input  logic                      slot_sel,
	output word_t                     slot_rdata,

	// status back from the target side
	input  logic                      target_dataslot_ack,
	input  logic                      target_dataslot_done,
	input  logic [SLOT_ERR_WIDTH-1:0] target_dataslot_err,

	// command pulses and parameters
	output logic                      target_dataslot_read,
	output logic                      target_dataslot_write,
	output logic [15:0]               target_dataslot_id,
	output word_t                     target_dataslot_bridgeaddr,
	output word_t                     target_dataslot_length,
	output word_t                     target_dataslot_slotoffset
);

	logic  wr_hit; // write strobe for this block
	logic  rd_hit;
	word_t status_word;

	assign wr_hit = acc_stb && slot_sel && acc_we;
	assign rd_hit = acc_stb && slot_sel && !acc_we;

	// ack bit 4, done bit 3, err in 2:0
	assign status_word = word_t'({target_dataslot_ack, target_dataslot_done,
		target_dataslot_err});

	// parameter registers, whole-word writes
	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			target_dataslot_id         <= '0;
			target_dataslot_bridgeaddr <= '0;
			target_dataslot_length     <= '0;
			target_dataslot_slotoffset <= '0;
		end else if (wr_hit) begin
			case (acc_addr.regs.offset)
				OFS_SLOT_ID:     target_dataslot_id <= acc_wdata[15:0]; // id is 16 bits only
				OFS_BRIDGE_ADDR: target_dataslot_bridgeaddr <= acc_wdata;
				OFS_LENGTH:      target_dataslot_length <= acc_wdata;
				OFS_SLOT_OFFSET: target_dataslot_slotoffset <= acc_wdata;
				default: ;
			endcase
		end
	end

	// command pulses, high for one cycle only
	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			target_dataslot_read  <= 1'b0;
			target_dataslot_write <= 1'b0;
		end else begin
			target_dataslot_read  <= 1'b0;
			target_dataslot_write <= 1'b0;
			if (wr_hit && acc_addr.regs.offset == OFS_SLOT_CTRL) begin
				target_dataslot_read  <= acc_wdata[0]; // bit 0 read
				target_dataslot_write <= acc_wdata[1]; // bit 1 write
			end
		end
	end

	// readback word, ready in the ack cycle
	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			slot_rdata <= '0;
		end else if (rd_hit) begin
			case (acc_addr.regs.offset)
				OFS_SLOT_ID:     slot_rdata <= word_t'(target_dataslot_id);
				OFS_BRIDGE_ADDR: slot_rdata <= target_dataslot_bridgeaddr;
				OFS_LENGTH:      slot_rdata <= target_dataslot_length;
				OFS_SLOT_OFFSET: slot_rdata <= target_dataslot_slotoffset;
				OFS_SLOT_CTRL:   slot_rdata <= status_word; // live status
				default:         slot_rdata <= '0;
			endcase
		end
	end

endmodule

//--- logic/mcu_bus_decode.sv
`timescale 1ns/1ps

module mcu_bus_decode
	import mcu_periph_pkg::*;
#(
	parameter int TABLE_ADDR_WIDTH = 10
) (
	input  logic                        clk_sys,
	input  logic                        reset_n,

	// cpu bus, request held until ack
	input  logic                        cpu_req,
	input  word_t                       cpu_addr,
	input  word_t                       cpu_wdata,
	input  logic [3:0]                  cpu_wstrb,
	output logic                        cpu_ack,
	output word_t                       cpu_rdata,

	// external data table ram
	output logic [TABLE_ADDR_WIDTH-1:0] datatable_addr,
	output logic                        datatable_wren,
	output word_t                       datatable_data,
	input  word_t                       datatable_q,

	// access to the register blocks
	output logic                        acc_stb,
	output logic                        acc_we,
	output bus_addr_t                   acc_addr,
	output word_t                       acc_wdata,
	output logic                        slot_sel,
	output logic                        timer_sel,
	input  word_t                       slot_rdata,
	input  word_t                       timer_rdata,

	output logic                        reset_out
);

	bus_addr_t  cur_addr; // incoming address, both views
	bus_addr_t  req_addr; // captured request
	word_t      req_wdata;
	logic       req_we;
	logic       busy;
	logic       issue;    // first cycle after capture
	logic [1:0] wait_cnt; // cycles left before ack
	logic       is_tbl;
	logic       is_rst;
	logic       accept;
	logic       cur_we;
	logic       hit_page;
	logic       hit_tbl;
	logic       hit_regs;
	logic       hit_slot;
	logic       hit_timer;
	logic       hit_rst;

	assign cur_addr = cpu_addr;
	assign cur_we   = |cpu_wstrb; // any strobe means a whole-word write

	// classify on the incoming address
	assign hit_page  = cur_addr.tbl.page == PERIPH_PAGE;
	assign hit_tbl   = hit_page && cur_addr.tbl.region == TABLE_REGION;
	assign hit_regs  = hit_page && cur_addr.regs.group == REG_GROUP;
	assign hit_slot  = hit_regs && (cur_addr.regs.offset inside {OFS_SLOT_ID,
		OFS_BRIDGE_ADDR, OFS_LENGTH, OFS_SLOT_OFFSET, OFS_SLOT_CTRL});
	assign hit_timer = hit_regs && (cur_addr.regs.offset inside {OFS_TICK_PERIOD,
		OFS_MS_COUNT});
	assign hit_rst   = hit_regs && cur_addr.regs.offset == OFS_RESET_OUT;

	// new request only when idle and not in the ack cycle
	assign accept = cpu_req && !busy && !cpu_ack;

	// capture, wait counter and ack
	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			busy      <= 1'b0;
			issue     <= 1'b0;
			wait_cnt  <= '0;
			cpu_ack   <= 1'b0;
			req_addr  <= '0;
			req_wdata <= '0;
			req_we    <= 1'b0;
			is_tbl    <= 1'b0;
			is_rst    <= 1'b0;
			slot_sel  <= 1'b0;
			timer_sel <= 1'b0;
		end else begin
			cpu_ack <= 1'b0;
			issue   <= accept;
			if (accept) begin
				busy      <= 1'b1;
				req_addr  <= cur_addr;
				req_wdata <= cpu_wdata;
				req_we    <= cur_we;
				is_tbl    <= hit_tbl;
				is_rst    <= hit_rst;
				slot_sel  <= hit_slot;
				timer_sel <= hit_timer;
				// table read waits one more for the ram
				wait_cnt  <= (hit_tbl && !cur_we) ? 2'd2 : 2'd1;
			end else if (busy) begin
				if (wait_cnt != 2'd0) begin
					wait_cnt <= wait_cnt - 2'd1;
				end else begin
					cpu_ack <= 1'b1;
					busy    <= 1'b0;
				end
			end
		end
	end

	// strobes one cycle after capture
	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			acc_stb        <= 1'b0;
			datatable_wren <= 1'b0;
			reset_out      <= 1'b0;
		end else begin
			acc_stb        <= issue && (slot_sel || timer_sel);
			datatable_wren <= issue && is_tbl && req_we;
			if (issue && is_rst && req_we)
				reset_out <= req_wdata[0]; // core reset, bit 0 only
		end
	end

	assign acc_we    = req_we;
	assign acc_addr  = req_addr;
	assign acc_wdata = req_wdata;

	// ram sees the held request
	assign datatable_addr = TABLE_ADDR_WIDTH'(req_addr.tbl.index);
	assign datatable_data = req_wdata;

	// read mux, foreign page and unknown offsets read zero
	always_comb begin
		cpu_rdata = '0;
		if (is_tbl)
			cpu_rdata = datatable_q;
		else if (slot_sel)
			cpu_rdata = slot_rdata;
		else if (timer_sel)
			cpu_rdata = timer_rdata;
		else if (is_rst)
			cpu_rdata = word_t'(reset_out);
	end

endmodule

//--- logic/mcu_periph_pkg.sv
package mcu_periph_pkg;

	// one bus data word
	typedef logic [31:0] word_t;

	// address seen as a data-table access
	typedef struct packed {
		logic [15:0] page;   // FFFF for the peripheral block
		logic [3:0]  region; // 0 selects the table
		logic [9:0]  index;  // word index into the table
		logic [1:0]  lane;   // byte lane, ignored
	} tbl_view_t;

	// same address seen as a register access
	typedef struct packed {
		logic [15:0] page;
		logic [7:0]  group;  // FF selects the register group
		logic [7:0]  offset; // register offset within the group
	} reg_view_t;

	// cpu address decoded two ways
	typedef union packed {
		tbl_view_t tbl;
		reg_view_t regs;
	} bus_addr_t;

	localparam logic [15:0] PERIPH_PAGE  = 16'hFFFF;
	localparam logic [3:0]  TABLE_REGION = 4'h0;
	localparam logic [7:0]  REG_GROUP    = 8'hFF;

	// dataslot command block
	localparam logic [7:0] OFS_SLOT_ID     = 8'h80;
	localparam logic [7:0] OFS_BRIDGE_ADDR = 8'h84;
	localparam logic [7:0] OFS_LENGTH      = 8'h88;
	localparam logic [7:0] OFS_SLOT_OFFSET = 8'h8C;
	localparam logic [7:0] OFS_SLOT_CTRL   = 8'h90; // w: pulses, r: status

	// millisecond timer
	localparam logic [7:0] OFS_TICK_PERIOD = 8'h98;
	localparam logic [7:0] OFS_MS_COUNT    = 8'hC8; // write bit 0 to clear

	localparam logic [7:0] OFS_RESET_OUT   = 8'hA4;

	localparam int SLOT_ERR_WIDTH = 3;

endpackage

//--- logic/mcu_periph_top.sv
`timescale 1ns/1ps

module mcu_periph_top
	import mcu_periph_pkg::*;
#(
	parameter int TABLE_ADDR_WIDTH = 10,
	parameter int TICK_WIDTH       = 20
) (
	input  logic                        clk_sys,
	input  logic                        reset_n,

	// cpu native bus
	input  logic                        cpu_req,
	input  word_t                       cpu_addr,
	input  word_t                       cpu_wdata,
	input  logic [3:0]                  cpu_wstrb,
	output logic                        cpu_ack,
	output word_t                       cpu_rdata,

	// data table ram
	output logic [TABLE_ADDR_WIDTH-1:0] datatable_addr,
	output logic                        datatable_wren,
	output word_t                       datatable_data,
	input  word_t                       datatable_q,

	// dataslot target
	output logic                        target_dataslot_read,
	output logic                        target_dataslot_write,
	input  logic                        target_dataslot_ack,
	input  logic                        target_dataslot_done,
	input  logic [SLOT_ERR_WIDTH-1:0]   target_dataslot_err,
	output logic [15:0]                 target_dataslot_id,
	output word_t                       target_dataslot_bridgeaddr,
	output word_t                       target_dataslot_length,
	output word_t                       target_dataslot_slotoffset,

	output logic                        reset_out
);

	logic      acc_stb;
	logic      acc_we;
	bus_addr_t acc_addr;
	word_t     acc_wdata;
	logic      slot_sel;
	logic      timer_sel;
	word_t     slot_rdata;
	word_t     timer_rdata;

	mcu_bus_decode #(
		.TABLE_ADDR_WIDTH (TABLE_ADDR_WIDTH)
	) mcu_bus_decode_inst (
		.clk_sys        (clk_sys),
		.reset_n        (reset_n),
		.cpu_req        (cpu_req),
		.cpu_addr       (cpu_addr),
		.cpu_wdata      (cpu_wdata),
		.cpu_wstrb      (cpu_wstrb),
		.cpu_ack        (cpu_ack),
		.cpu_rdata      (cpu_rdata),
		.datatable_addr (datatable_addr),
		.datatable_wren (datatable_wren),
		.datatable_data (datatable_data),
		.datatable_q    (datatable_q),
		.acc_stb        (acc_stb),
		.acc_we         (acc_we),
		.acc_addr       (acc_addr),
		.acc_wdata      (acc_wdata),
		.slot_sel       (slot_sel),
		.timer_sel      (timer_sel),
		.slot_rdata     (slot_rdata),
		.timer_rdata    (timer_rdata),
		.reset_out      (reset_out)
	);

	dataslot_cmd_regs dataslot_cmd_regs_inst (
		.clk_sys                    (clk_sys),
		.reset_n                    (reset_n),
		.acc_stb                    (acc_stb),
		.acc_we                     (acc_we),
		.acc_addr                   (acc_addr),
		.acc_wdata                  (acc_wdata),
		.slot_sel                   (slot_sel),
		.slot_rdata                 (slot_rdata),
		.target_dataslot_ack        (target_dataslot_ack),
		.target_dataslot_done       (target_dataslot_done),
		.target_dataslot_err        (target_dataslot_err),
		.target_dataslot_read       (target_dataslot_read),
		.target_dataslot_write      (target_dataslot_write),
		.target_dataslot_id         (target_dataslot_id),
		.target_dataslot_bridgeaddr (target_dataslot_bridgeaddr),
		.target_dataslot_length     (target_dataslot_length),
		.target_dataslot_slotoffset (target_dataslot_slotoffset)
	);

	ms_timer #(
		.TICK_WIDTH (TICK_WIDTH)
	) ms_timer_inst (
		.clk_sys     (clk_sys),
		.reset_n     (reset_n),
		.acc_stb     (acc_stb),
		.acc_we      (acc_we),
		.acc_addr    (acc_addr),
		.acc_wdata   (acc_wdata),
		.timer_sel   (timer_sel),
		.timer_rdata (timer_rdata)
	);

endmodule

//--- logic/ms_timer.sv
`timescale 1ns/1ps

module ms_timer
	import mcu_periph_pkg::*;
#(
	parameter int TICK_WIDTH = 20
) (
	input  logic      clk_sys,
	input  logic      reset_n,
	input  logic      acc_stb,
	input  logic      acc_we,
	input  bus_addr_t acc_addr,
	input  word_t     acc_wdata,
	input  logic      timer_sel,
	output word_t     timer_rdata
);

	logic [TICK_WIDTH-1:0] tick_period; // cycles per ms, minus one
	logic [TICK_WIDTH-1:0] prescale;
	word_t                 ms_count;
	logic                  wr_hit;
	logic                  ms_clear;
	logic                  tick_end;

	assign wr_hit   = acc_stb && timer_sel && acc_we;
	assign ms_clear = wr_hit && acc_addr.regs.offset == OFS_MS_COUNT && acc_wdata[0];
	assign tick_end = prescale == tick_period; // terminal count

	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n)
			tick_period <= '0;
		else if (wr_hit && acc_addr.regs.offset == OFS_TICK_PERIOD)
			tick_period <= acc_wdata[TICK_WIDTH-1:0];
	end

	// prescaler wraps at the period, counter steps on the wrap
	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			prescale <= '0;
			ms_count <= '0;
		end else if (ms_clear) begin
			prescale <= '0; // restart the ms from here
			ms_count <= '0;
		end else if (tick_end) begin
			prescale <= '0;
			ms_count <= ms_count + 32'd1;
		end else begin
			prescale <= prescale + 1'b1;
		end
	end

	// registered readback
	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			timer_rdata <= '0;
		end else if (acc_stb && timer_sel && !acc_we) begin
			case (acc_addr.regs.offset)
				OFS_TICK_PERIOD: timer_rdata <= word_t'(tick_period);
				OFS_MS_COUNT:    timer_rdata <= ms_count;
				default:         timer_rdata <= '0;
			endcase
		end
	end

endmodule

//--- test/mcu_periph_checker.sv
`timescale 1ns/1ps

module mcu_periph_checker (
	input logic clk_sys,
	input logic reset_n,
	input logic cpu_req,
	input logic cpu_ack,
	input logic target_dataslot_read,
	input logic target_dataslot_write
);

	// ack is a single-cycle pulse
	ack_single: assert property (@(posedge clk_sys) disable iff (!reset_n)
		cpu_ack |=> !cpu_ack)
		else $error("cpu_ack high two cycles running");

	ack_after_req: assert property (@(posedge clk_sys) disable iff (!reset_n)
		cpu_ack |-> $past(cpu_req)) // request was held up to the ack
		else $error("cpu_ack without a request the cycle before");

	cmd_exclusive: assert property (@(posedge clk_sys) disable iff (!reset_n)
		!(target_dataslot_read && target_dataslot_write))
		else $error("read and write command pulses high together");

	rd_pulse_one: assert property (@(posedge clk_sys) disable iff (!reset_n)
		target_dataslot_read |=> !target_dataslot_read)
		else $error("target_dataslot_read longer than one cycle");

	wr_pulse_one: assert property (@(posedge clk_sys) disable iff (!reset_n)
		target_dataslot_write |=> !target_dataslot_write)
		else $error("target_dataslot_write longer than one cycle");

endmodule

//--- test/mcu_periph_tb.sv
`timescale 1ns/1ps

module mcu_periph_tb
	import mcu_periph_pkg::*;
();

	localparam logic [3:0] K_NONE   = 4'd0; // ack timing only
	localparam logic [3:0] K_RDATA  = 4'd1;
	localparam logic [3:0] K_TBL    = 4'd2; // rdata plus ram address
	localparam logic [3:0] K_PORT   = 4'd3; // output port picked by offset
	localparam logic [3:0] K_PULSE  = 4'd4; // exp = {write count, read count}
	localparam logic [3:0] K_STATUS = 4'd5; // wdata[4:0] driven as ack, done, err
	localparam logic [3:0] K_TIMER0 = 4'd6;
	localparam logic [3:0] K_TIMER1 = 4'd7; // wdata = idle cycles before the read

	typedef struct packed {
		logic       we;
		word_t      addr;
		word_t      wdata;
		word_t      exp;
		logic [3:0] kind;
	} entry_t;

	logic        clk_sys, reset_n, cpu_req, cpu_ack, reset_out;
	word_t       cpu_addr, cpu_wdata, cpu_rdata, datatable_data, datatable_q;
	logic [3:0]  cpu_wstrb;
	logic [9:0]  datatable_addr;
	logic        datatable_wren, target_dataslot_read, target_dataslot_write;
	logic        target_dataslot_ack, target_dataslot_done;
	logic [2:0]  target_dataslot_err;
	logic [15:0] target_dataslot_id;
	word_t       target_dataslot_bridgeaddr, target_dataslot_length;
	word_t       target_dataslot_slotoffset;

	word_t  ram [1024];  // data table model
	entry_t tests[$];
	logic   table_ready = 1'b0;
	int     cycle_cnt = 0;
	int     errors = 0;
	int     checks = 0;

	mcu_periph_top #(.TABLE_ADDR_WIDTH(10), .TICK_WIDTH(20)) mcu_periph_top_inst (.*);

	bind mcu_periph_top mcu_periph_checker mcu_periph_checker_inst (
		.clk_sys, .reset_n, .cpu_req, .cpu_ack,
		.target_dataslot_read, .target_dataslot_write
	);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys; // 8 ns period
	end

	always @(posedge clk_sys)
		cycle_cnt <= cycle_cnt + 1;

	// synchronous ram with q one cycle after the address
	always @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			datatable_q <= '0;
		end else begin
			if (datatable_wren)
				ram[datatable_addr] <= datatable_data;
			datatable_q <= ram[datatable_addr]; // old data on a same-cycle write
		end
	end

	// xorshift32
	function automatic word_t next_random(input word_t s);
		word_t x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	function automatic word_t reg_addr(input logic [7:0] ofs);
		return {24'hFFFF_FF, ofs}; // page FFFF, group FF
	endfunction

	task automatic add_entry(input logic we, input word_t addr, input word_t wdata,
		input word_t exp, input logic [3:0] kind);
		tests.push_back(entry_t'({we, addr, wdata, exp, kind}));
	endtask

	task automatic check_value(input string name, input word_t exp, input word_t act);
		checks++;
		assert (act === exp) else begin
			errors++;
			$display("ERROR t=%0t %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	// parameter and reset ports picked by register offset
	task automatic check_port(input logic [7:0] ofs, input word_t exp);
		case (ofs)
			OFS_SLOT_ID:
				check_value("target_dataslot_id", exp, word_t'(target_dataslot_id));
			OFS_BRIDGE_ADDR:
				check_value("target_dataslot_bridgeaddr", exp, target_dataslot_bridgeaddr);
			OFS_LENGTH:
				check_value("target_dataslot_length", exp, target_dataslot_length);
			OFS_SLOT_OFFSET:
				check_value("target_dataslot_slotoffset", exp, target_dataslot_slotoffset);
			default:
				check_value("reset_out", exp, word_t'(reset_out));
		endcase
	endtask

	// one bus access with read data, ack latency and strobe counts back
	task automatic run_access(input entry_t t, output word_t rdata, output int lat,
		output int rd_cnt, output int wr_cnt, output int wren_cnt);
		int n;
		n = 0;
		rd_cnt = 0;
		wr_cnt = 0;
		wren_cnt = 0;
		rdata = '0;
		@(negedge clk_sys);
		cpu_req   = 1'b1;
		cpu_addr  = t.addr;
		cpu_wdata = t.wdata;
		cpu_wstrb = t.we ? 4'hF : 4'h0;
		while (cpu_req) begin
			@(negedge clk_sys);
			n++;
			rd_cnt += int'(target_dataslot_read);
			wr_cnt += int'(target_dataslot_write);
			if (datatable_wren) begin
				wren_cnt++;
				check_value("datatable_data", t.wdata, datatable_data);
			end
			if (cpu_ack) begin
				rdata     = cpu_rdata;
				cpu_req   = 1'b0; // dropped in the ack cycle
				cpu_wstrb = 4'h0;
			end
		end
		lat = n - 1; // first negedge already follows the sampling edge
		@(negedge clk_sys);
		rd_cnt += int'(target_dataslot_read);
		wr_cnt += int'(target_dataslot_write);
		wren_cnt += int'(datatable_wren);
		check_value("cpu_ack", '0, word_t'(cpu_ack)); // ack lasts one cycle
	endtask

	initial begin
		logic [9:0] idx [5];
		logic       tbl_acc;
		word_t      seed;
		word_t      rdata;
		word_t      ms_first;
		int         lat, exp_lat, rd_cnt, wr_cnt, err_before, cyc_first, steps, delta;
		int         wren_cnt, exp_wren;

		cpu_req              = 1'b0;
		cpu_addr             = '0;
		cpu_wdata            = '0;
		cpu_wstrb            = '0;
		target_dataslot_ack  = 1'b0;
		target_dataslot_done = 1'b0;
		target_dataslot_err  = '0;
		reset_n              = 1'b0;
		ms_first             = '0;
		cyc_first            = 0;

		// same seed twice so the table reads know the words
		idx  = '{10'd0, 10'd5, 10'd42, 10'd511, 10'd1023};
		seed = 32'h6f43_1787;
		foreach (idx[k]) begin
			seed = next_random(seed);
			add_entry(1'b1, {16'hFFFF, 4'h0, idx[k], 2'b00}, seed, '0, K_NONE);
		end
		seed = 32'h6f43_1787;
		foreach (idx[k]) begin
			seed = next_random(seed);
			add_entry(1'b0, {16'hFFFF, 4'h0, idx[k], 2'b00}, '0, seed, K_TBL);
		end
		// id keeps 16 bits
		add_entry(1'b1, reg_addr(OFS_SLOT_ID), 32'h5A5A_C3E1, 32'h0000_C3E1, K_PORT);
		add_entry(1'b0, reg_addr(OFS_SLOT_ID), '0, 32'h0000_C3E1, K_RDATA);
		add_entry(1'b1, reg_addr(OFS_BRIDGE_ADDR), 32'h8000_1240, 32'h8000_1240, K_PORT);
		add_entry(1'b0, reg_addr(OFS_BRIDGE_ADDR), '0, 32'h8000_1240, K_RDATA);
		add_entry(1'b1, reg_addr(OFS_LENGTH), 32'h0002_0000, 32'h0002_0000, K_PORT);
		add_entry(1'b0, reg_addr(OFS_LENGTH), '0, 32'h0002_0000, K_RDATA);
		add_entry(1'b1, reg_addr(OFS_SLOT_OFFSET), 32'h0000_0C00, 32'h0000_0C00, K_PORT);
		add_entry(1'b0, reg_addr(OFS_SLOT_OFFSET), '0, 32'h0000_0C00, K_RDATA);
		add_entry(1'b1, reg_addr(OFS_SLOT_CTRL), 32'd1, 32'd1, K_PULSE); // read cmd only
		add_entry(1'b1, reg_addr(OFS_SLOT_CTRL), 32'd2, 32'd2, K_PULSE); // write cmd only
		add_entry(1'b0, reg_addr(OFS_SLOT_CTRL), 32'h15, 32'h15, K_STATUS); // ack and err 5
		add_entry(1'b0, reg_addr(OFS_SLOT_CTRL), 32'h0B, 32'h0B, K_STATUS); // done and err 3
		add_entry(1'b1, reg_addr(OFS_TICK_PERIOD), 32'd3, '0, K_NONE);
		add_entry(1'b0, reg_addr(OFS_TICK_PERIOD), '0, 32'd3, K_RDATA);
		add_entry(1'b1, reg_addr(OFS_MS_COUNT), 32'd1, '0, K_NONE); // clear
		add_entry(1'b0, reg_addr(OFS_MS_COUNT), '0, '0, K_TIMER0);
		add_entry(1'b0, reg_addr(OFS_MS_COUNT), 32'd40, '0, K_TIMER1);
		add_entry(1'b1, reg_addr(OFS_RESET_OUT), 32'd1, 32'd1, K_PORT);
		add_entry(1'b0, reg_addr(OFS_RESET_OUT), '0, 32'd1, K_RDATA);
		add_entry(1'b1, reg_addr(OFS_RESET_OUT), 32'd0, 32'd0, K_PORT);
		add_entry(1'b0, 32'h0000_1000, '0, '0, K_RDATA); // foreign pages read zero
		add_entry(1'b0, 32'h1234_0010, '0, '0, K_RDATA);
		table_ready = 1'b1;

		repeat (5) @(negedge clk_sys);
		reset_n = 1'b1;

		foreach (tests[i]) begin
			err_before = errors;
			if (tests[i].kind == K_STATUS)
				{target_dataslot_ack, target_dataslot_done, target_dataslot_err} =
					tests[i].wdata[4:0];
			if (tests[i].kind == K_TIMER1)
				repeat (tests[i].wdata) @(negedge clk_sys);
			run_access(tests[i], rdata, lat, rd_cnt, wr_cnt, wren_cnt);
			tbl_acc = tests[i].addr[31:12] == 20'hFFFF0; // data-table window
			// table reads wait one more cycle for the ram
			exp_lat  = (tbl_acc && !tests[i].we) ? 3 : 2;
			exp_wren = (tbl_acc && tests[i].we) ? 1 : 0; // one wren per table write
			check_value("cpu_ack latency", exp_lat, lat);
			check_value("datatable_wren pulses", exp_wren, wren_cnt);
			case (tests[i].kind)
				K_RDATA, K_STATUS: check_value("cpu_rdata", tests[i].exp, rdata);
				K_TBL: begin
					check_value("cpu_rdata", tests[i].exp, rdata);
					check_value("datatable_addr", word_t'(tests[i].addr[11:2]),
						word_t'(datatable_addr));
				end
				K_PORT: check_port(tests[i].addr[7:0], tests[i].exp);
				K_PULSE: begin
					check_value("target_dataslot_read pulses", word_t'(tests[i].exp[0]), rd_cnt);
					check_value("target_dataslot_write pulses", word_t'(tests[i].exp[1]), wr_cnt);
				end
				K_TIMER0: begin
					ms_first  = rdata;
					cyc_first = cycle_cnt;
				end
				K_TIMER1: begin
					steps = (cycle_cnt - cyc_first) / 4; // period 3 means 4 cycles per ms
					delta = int'(rdata - ms_first);
					checks++;
					assert (delta >= steps - 1 && delta <= steps + 1) else begin
						errors++;
						$display("ERROR t=%0t ms_count delta expected %0d +-1 got %0d",
							$time, steps, delta);
					end
				end
				default: ;
			endcase
			$display("entry %0d %s %h %s", i, tests[i].we ? "wr" : "rd", tests[i].addr,
				(errors == err_before) ? "ok" : "FAIL");
		end

		$display("entries %0d checks %0d errors %0d", tests.size(), checks, errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

	// watchdog allows 20 cycles per table entry
	initial begin
		wait (table_ready);
		repeat (tests.size() * 20) @(posedge clk_sys);
		$display("TIMEOUT: table not finished within %0d cycles", tests.size() * 20);
		$display("test failed");
		$finish;
	end

endmodule
